// File: hw/exe_pkg.sv
`default_nettype none

package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [4:0]  load_op_t;   // one-hot b, h, w, bu, hu
    typedef logic [2:0]  store_op_t;  // one-hot b, h, w
    typedef logic [1:0]  time_op_t;   // bit 0 low half, bit 1 high half
    typedef logic [5:0]  ecode_t;
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [3:0]  tlb_idx_t;   // wide enough for 16 entries

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLT    = 4'd2;
    localparam alu_op_t ALU_SLTU   = 4'd3;
    localparam alu_op_t ALU_AND    = 4'd4;
    localparam alu_op_t ALU_OR     = 4'd5;
    localparam alu_op_t ALU_XOR    = 4'd6;
    localparam alu_op_t ALU_NOR    = 4'd7;
    localparam alu_op_t ALU_SLL    = 4'd8;
    localparam alu_op_t ALU_SRL    = 4'd9;
    localparam alu_op_t ALU_SRA    = 4'd10;
    localparam alu_op_t ALU_LUI    = 4'd11;
    localparam alu_op_t ALU_DIV_WU = 4'd12;
    localparam alu_op_t ALU_MOD_WU = 4'd13;

    localparam ecode_t ECODE_NONE = 6'h00;
    localparam ecode_t ECODE_PIL  = 6'h01;
    localparam ecode_t ECODE_PIS  = 6'h02;
    localparam ecode_t ECODE_PME  = 6'h04;
    localparam ecode_t ECODE_ALE  = 6'h09;
    localparam ecode_t ECODE_TLBR = 6'h3f;

    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     alu_src1;
        word_t     alu_src2;
        load_op_t  load_op;
        store_op_t store_op;
        word_t     rkd_value;
        logic      gr_we;
        reg_idx_t  dest;
        time_op_t  time_op;
    } ds2es_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        load_op_t load_op;
        reg_idx_t dest;
        logic     gr_we;
        logic     ex;
        ecode_t   ecode;
        word_t    bad_va;
    } es2ms_t;

    typedef struct packed {
        logic     rf_we;
        reg_idx_t dest;
        word_t    result;
    } forward_t;

    typedef struct packed {
        vppn_t vppn;
        logic  ps4mb;
        ppn_t  ppn;
        logic  v;
        logic  d;
        logic  e;
    } tlb_entry_t;

    typedef struct packed {
        logic     found;
        tlb_idx_t index;
        ppn_t     ppn;
        logic     ps4mb;
        logic     v;
        logic     d;
    } tlb_result_t;

endpackage

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import exe_pkg::*; (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire alu_op_t op,
    input  wire word_t   src1,
    input  wire word_t   src2,
    input  wire logic    start,
    output logic         flag,
    output word_t        result
);

    logic        is_div;
    logic        busy;
    logic        done;
    logic [4:0]  cnt;
    word_t       div_rem;
    word_t       div_quo;
    word_t       divisor;
    logic [32:0] shifted;
    logic [32:0] diff;

    assign is_div = (op == ALU_DIV_WU) || (op == ALU_MOD_WU);

    // one restoring step per cycle
    assign shifted = {div_rem, div_quo[31]};
    assign diff    = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= 5'd0;
        end else if (start && is_div) begin
            busy <= 1'b1;
            done <= 1'b0;
            cnt  <= 5'd0;
        end else if (busy) begin
            cnt <= cnt + 5'd1;
            if (cnt == 5'd31) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && is_div) begin
            div_rem <= '0;
            div_quo <= src1;
            divisor <= src2;
        end else if (busy) begin
            if (!diff[32]) begin
                div_rem <= diff[31:0];
                div_quo <= {div_quo[30:0], 1'b1};
            end else begin
                div_rem <= shifted[31:0];
                div_quo <= {div_quo[30:0], 1'b0};
            end
        end
    end

    // a zero divisor never borrows, so quotient ends all ones and remainder is the dividend
    assign flag = is_div ? (done && !start) : 1'b1;

    always_comb begin
        case (op)
            ALU_ADD:    result = src1 + src2;
            ALU_SUB:    result = src1 - src2;
            ALU_SLT:    result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU:   result = {31'b0, src1 < src2};
            ALU_AND:    result = src1 & src2;
            ALU_OR:     result = src1 | src2;
            ALU_XOR:    result = src1 ^ src2;
            ALU_NOR:    result = ~(src1 | src2);
            ALU_SLL:    result = src1 << src2[4:0];
            ALU_SRL:    result = src1 >> src2[4:0];
            ALU_SRA:    result = word_t'($signed(src1) >>> src2[4:0]);
            ALU_LUI:    result = src2;  // decode already shifted the immediate
            ALU_DIV_WU: result = div_quo;
            ALU_MOD_WU: result = div_rem;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/tlb_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup import exe_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           we,
    input  wire logic [$clog2(TLB_ENTRIES)-1:0] windex,
    input  wire tlb_entry_t                     wentry,
    input  wire vppn_t                          vppn,
    output tlb_result_t                         result
);

    tlb_entry_t entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i].e <= 1'b0;
            end
        end else if (we) begin
            entries[windex] <= wentry;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entries[i].ps4mb) begin
                hit[i] = entries[i].e && (entries[i].vppn[18:9] == vppn[18:9]);  // 4MB page
            end else begin
                hit[i] = entries[i].e && (entries[i].vppn == vppn);
            end
        end
    end

    // walk down so the lowest matching index wins
    always_comb begin
        result = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                result.found = 1'b1;
                result.index = tlb_idx_t'(i);
                result.ppn   = entries[i].ppn;
                result.ps4mb = entries[i].ps4mb;
                result.v     = entries[i].v;
                result.d     = entries[i].d;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mmu_translate.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_translate import exe_pkg::*; (
    input  wire word_t       va,
    input  wire logic        is_store,
    input  wire logic        crmd_da,
    input  wire word_t       dmw0,
    input  wire word_t       dmw1,
    input  wire tlb_result_t tlb,
    output word_t            pa,
    output ecode_t           ecode
);

    logic  dmw0_hit;
    logic  dmw1_hit;
    word_t tlb_pa;

    assign dmw0_hit = dmw0[0] && (va[31:29] == dmw0[31:29]);
    assign dmw1_hit = dmw1[0] && (va[31:29] == dmw1[31:29]);

    assign tlb_pa = tlb.ps4mb ? {tlb.ppn[19:10], va[21:0]}
                              : {tlb.ppn, va[11:0]};

    always_comb begin
        pa    = va;
        ecode = ECODE_NONE;
        if (crmd_da) begin
            pa = va;
        end else if (dmw0_hit) begin
            pa = {dmw0[27:25], va[28:0]};
        end else if (dmw1_hit) begin
            pa = {dmw1[27:25], va[28:0]};
        end else begin
            pa = tlb_pa;
            if (!tlb.found) begin
                ecode = ECODE_TLBR;
            end else if (!tlb.v) begin
                ecode = is_store ? ECODE_PIS : ECODE_PIL;
            end else if (is_store && !tlb.d) begin
                ecode = ECODE_PME;     // first write to a clean page
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage import exe_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        in_valid,
    input  wire ds2es_t      in_bus,
    output logic             in_allowin,
    input  wire logic        out_allowin,
    output logic             out_valid,
    output es2ms_t           out_bus,
    input  wire logic        flush,
    output forward_t         fwd,
    output logic             mem_en,
    output logic             mem_wr,
    output logic [1:0]       mem_size,
    output logic [3:0]       mem_strb,
    output word_t            mem_addr,
    output word_t            mem_wdata,
    input  wire logic        mem_addr_ok,
    input  wire logic        crmd_da,
    input  wire word_t       dmw0,
    input  wire word_t       dmw1,
    output vppn_t            lookup_vppn,
    input  wire tlb_result_t lookup_result
);

    ds2es_t      es_bus;
    logic        es_valid;
    logic        es_fresh;    // first cycle of the held instruction
    logic [63:0] counter;

    word_t       alu_result;
    logic        alu_flag;
    word_t       pa;
    ecode_t      mmu_ecode;

    logic        need_mem;
    logic        is_store;
    logic        ale;
    logic        mem_ex;
    ecode_t      es_ecode;
    logic        ready_go;
    word_t       final_result;
    logic [3:0]  byte_sel;
    logic [3:0]  st_strb;
    word_t       st_data;

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_bus <= in_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (flush) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            es_fresh <= 1'b0;
        end else begin
            es_fresh <= in_valid && in_allowin && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= 64'd0;
        end else begin
            counter <= counter + 64'd1;
        end
    end

    alu u_alu (
        .clk    (clk),
        .reset  (reset),
        .op     (es_bus.alu_op),
        .src1   (es_bus.alu_src1),
        .src2   (es_bus.alu_src2),
        .start  (es_valid && es_fresh),
        .flag   (alu_flag),
        .result (alu_result)
    );

    assign lookup_vppn = alu_result[31:13];

    mmu_translate u_mmu (
        .va       (alu_result),
        .is_store (is_store),
        .crmd_da  (crmd_da),
        .dmw0     (dmw0),
        .dmw1     (dmw1),
        .tlb      (lookup_result),
        .pa       (pa),
        .ecode    (mmu_ecode)
    );

    assign is_store = |es_bus.store_op;
    assign need_mem = (|es_bus.load_op) || is_store;

    assign ale = ((es_bus.load_op[1] || es_bus.load_op[4] || es_bus.store_op[1])
                  && alu_result[0])
              || ((es_bus.load_op[2] || es_bus.store_op[2])
                  && (alu_result[1] || alu_result[0]));

    // misalignment is reported ahead of any translation fault
    assign mem_ex   = need_mem && (ale || (mmu_ecode != ECODE_NONE));
    assign es_ecode = !mem_ex ? ECODE_NONE
                    : ale     ? ECODE_ALE
                    : mmu_ecode;

    assign ready_go   = flush || (need_mem ? ((mem_en && mem_addr_ok) || mem_ex)
                                           : alu_flag);
    assign in_allowin = !es_valid || (ready_go && out_allowin);
    assign out_valid  = es_valid && ready_go && !flush;

    assign mem_en = es_valid && need_mem && !mem_ex && out_allowin && !flush;
    assign mem_wr = is_store;
    assign mem_addr = pa;

    assign mem_size = (es_bus.load_op[0] || es_bus.load_op[3] || es_bus.store_op[0]) ? 2'd0
                    : (es_bus.load_op[1] || es_bus.load_op[4] || es_bus.store_op[1]) ? 2'd1
                    : 2'd2;

    always_comb begin
        case (alu_result[1:0])
            2'd0:    byte_sel = 4'b0001;
            2'd1:    byte_sel = 4'b0010;
            2'd2:    byte_sel = 4'b0100;
            default: byte_sel = 4'b1000;
        endcase
    end

    assign st_strb = ({4{es_bus.store_op[0]}} & byte_sel)
                   | ({4{es_bus.store_op[1]}} & (alu_result[1] ? 4'b1100 : 4'b0011))
                   | ({4{es_bus.store_op[2]}} & 4'b1111);
    assign mem_strb = is_store ? st_strb : 4'b0000;

    assign st_data = ({32{es_bus.store_op[0]}} & {4{es_bus.rkd_value[7:0]}})
                   | ({32{es_bus.store_op[1]}} & {2{es_bus.rkd_value[15:0]}})
                   | ({32{es_bus.store_op[2]}} & es_bus.rkd_value);
    assign mem_wdata = st_data;

    assign final_result = es_bus.time_op[0] ? counter[31:0]
                        : es_bus.time_op[1] ? counter[63:32]
                        : need_mem          ? pa
                        : alu_result;

    always_comb begin
        out_bus.pc      = es_bus.pc;
        out_bus.result  = final_result;
        out_bus.load_op = es_bus.load_op;
        out_bus.dest    = es_bus.dest;
        out_bus.gr_we   = es_bus.gr_we;
        out_bus.ex      = mem_ex;
        out_bus.ecode   = es_ecode;
        out_bus.bad_va  = alu_result;   // virtual address of the access
    end

    always_comb begin
        fwd.rf_we  = es_valid && es_bus.gr_we;
        fwd.dest   = es_bus.dest;
        fwd.result = final_result;
    end

endmodule

`default_nettype wire

// File: hw/exe_top.sv
`timescale 1ns/1ps
`default_nettype none

module exe_top import exe_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           in_valid,
    input  wire ds2es_t                         in_bus,
    output logic                                in_allowin,
    input  wire logic                           out_allowin,
    output logic                                out_valid,
    output es2ms_t                              out_bus,
    input  wire logic                           flush,
    output forward_t                            fwd,
    output logic                                mem_en,
    output logic                                mem_wr,
    output logic [1:0]                          mem_size,
    output logic [3:0]                          mem_strb,
    output word_t                               mem_addr,
    output word_t                               mem_wdata,
    input  wire logic                           mem_addr_ok,
    input  wire logic                           crmd_da,
    input  wire word_t                          dmw0,
    input  wire word_t                          dmw1,
    input  wire logic                           tlb_we,
    input  wire logic [$clog2(TLB_ENTRIES)-1:0] tlb_windex,
    input  wire tlb_entry_t                     tlb_wentry
);

    vppn_t       lookup_vppn;
    tlb_result_t lookup_result;

    exe_stage u_exe_stage (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_bus        (in_bus),
        .in_allowin    (in_allowin),
        .out_allowin   (out_allowin),
        .out_valid     (out_valid),
        .out_bus       (out_bus),
        .flush         (flush),
        .fwd           (fwd),
        .mem_en        (mem_en),
        .mem_wr        (mem_wr),
        .mem_size      (mem_size),
        .mem_strb      (mem_strb),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_addr_ok   (mem_addr_ok),
        .crmd_da       (crmd_da),
        .dmw0          (dmw0),
        .dmw1          (dmw1),
        .lookup_vppn   (lookup_vppn),
        .lookup_result (lookup_result)
    );

    tlb_lookup #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk    (clk),
        .reset  (reset),
        .we     (tlb_we),
        .windex (tlb_windex),
        .wentry (tlb_wentry),
        .vppn   (lookup_vppn),
        .result (lookup_result)
    );

endmodule

`default_nettype wire

// File: sim/exe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exe_tb import exe_pkg::*; ();

    localparam load_op_t  LD_B  = 5'b00001;
    localparam load_op_t  LD_H  = 5'b00010;
    localparam load_op_t  LD_W  = 5'b00100;
    localparam load_op_t  LD_HU = 5'b10000;
    localparam store_op_t ST_B  = 3'b001;
    localparam store_op_t ST_H  = 3'b010;
    localparam store_op_t ST_W  = 3'b100;
    localparam word_t     DMW0  = 32'h8000_0001;  // 0x8.. maps to 0x0..
    localparam word_t     DMW1  = 32'ha200_0001;  // 0xa.. maps to 0x2..

    typedef struct {
        string      name;
        ds2es_t     bus;
        logic       da;
        int         stall;
        bit         flush_it;
        word_t      result;
        logic       ex;
        ecode_t     ecode;
        word_t      bad_va;
        logic [3:0] strb;
        logic [1:0] size;
        word_t      wdata;
        logic       mem;
    } test_t;

    logic clk, reset, in_valid, in_allowin, out_allowin, out_valid, flush;
    logic mem_en, mem_wr, mem_addr_ok, crmd_da, tlb_we;
    ds2es_t     in_bus;
    es2ms_t     out_bus;
    forward_t   fwd;
    logic [1:0] mem_size;
    logic [3:0] mem_strb;
    word_t      mem_addr, mem_wdata, dmw0, dmw1;
    logic [1:0] tlb_windex;
    tlb_entry_t tlb_wentry;

    test_t       tbl[$];
    tlb_entry_t  tlb_model[4];
    logic [63:0] ref_cnt;
    int          errors = 0;
    int          cur = 0;
    int          acc_cnt = 0;
    int          cycles = 0;
    int          limit = 100000;
    int          wait_cnt;
    logic        took, req;

    exe_top #(.TLB_ENTRIES(4)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t alu_ref(alu_op_t op, word_t a, word_t b);
        case (op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:   return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:    return a & b;
            ALU_OR:     return a | b;
            ALU_XOR:    return a ^ b;
            ALU_NOR:    return ~(a | b);
            ALU_SLL:    return a << b[4:0];
            ALU_SRL:    return a >> b[4:0];
            ALU_SRA:    return $signed(a) >>> b[4:0];
            ALU_LUI:    return b;
            ALU_DIV_WU: return (b == 0) ? 32'hffff_ffff : a / b;
            ALU_MOD_WU: return (b == 0) ? a : a % b;
            default:    return 32'd0;
        endcase
    endfunction

    task automatic translate(input word_t va, input logic st, input logic da,
                             output word_t pa, output ecode_t ec);
        int hit;
        hit = -1;
        pa = va;
        ec = ECODE_NONE;
        if (da) begin
            pa = va;
        end else if (DMW0[0] && va[31:29] == DMW0[31:29]) begin
            pa = {DMW0[27:25], va[28:0]};
        end else if (DMW1[0] && va[31:29] == DMW1[31:29]) begin
            pa = {DMW1[27:25], va[28:0]};
        end else begin
            for (int i = 3; i >= 0; i--) begin
                if (tlb_model[i].e && (tlb_model[i].ps4mb
                        ? tlb_model[i].vppn[18:9] == va[31:22]
                        : tlb_model[i].vppn == va[31:13])) hit = i;
            end
            if (hit < 0) begin
                ec = ECODE_TLBR;
            end else begin
                pa = tlb_model[hit].ps4mb ? {tlb_model[hit].ppn[19:10], va[21:0]}
                                          : {tlb_model[hit].ppn, va[11:0]};
                if (!tlb_model[hit].v) ec = st ? ECODE_PIS : ECODE_PIL;
                else if (st && !tlb_model[hit].d) ec = ECODE_PME;
            end
        end
    endtask

    task automatic add_test(input string name, input alu_op_t op, input word_t a, input word_t b,
                            input load_op_t ld, input store_op_t st, input word_t rkd,
                            input time_op_t tm, input logic da, input int stall, input bit fl);
        test_t  t;
        word_t  va;
        word_t  pa;
        ecode_t ec;
        logic   is_mem;
        logic   ale;
        t.name = name;
        t.bus = '0;
        t.bus.pc = 32'h1c00_0000 + 4 * tbl.size();
        t.bus.alu_op = op;
        t.bus.alu_src1 = a;
        t.bus.alu_src2 = b;
        t.bus.load_op = ld;
        t.bus.store_op = st;
        t.bus.rkd_value = rkd;
        t.bus.gr_we = (st == 0);
        t.bus.dest = reg_idx_t'(tbl.size() % 31 + 1);
        t.bus.time_op = tm;
        t.da = da;
        t.stall = stall;
        t.flush_it = fl;
        va = alu_ref(op, a, b);
        is_mem = (|ld) || (|st);
        translate(va, |st, da, pa, ec);
        ale = ((ld[1] || ld[4] || st[1]) && va[0]) || ((ld[2] || st[2]) && va[1:0] != 0);
        t.ex = is_mem && (ale || ec != ECODE_NONE);
        t.ecode = !t.ex ? ECODE_NONE : ale ? ECODE_ALE : ec;
        t.result = is_mem ? pa : va;
        t.bad_va = va;
        t.mem = is_mem && !t.ex;
        t.size = (ld[0] || ld[3] || st[0]) ? 2'd0 : (ld[1] || ld[4] || st[1]) ? 2'd1 : 2'd2;
        t.strb = st[0] ? 4'b0001 << va[1:0] : st[1] ? (va[1] ? 4'b1100 : 4'b0011)
               : st[2] ? 4'b1111 : 4'b0000;
        t.wdata = st[0] ? {4{rkd[7:0]}} : st[1] ? {2{rkd[15:0]}} : rkd;
        tbl.push_back(t);
    endtask

    task automatic add_alu(input string name, input alu_op_t op, input word_t a, input word_t b,
                           input int stall);
        add_test(name, op, a, b, 5'b0, 3'b0, 32'd0, 2'b0, 1'b1, stall, 1'b0);
    endtask

    task automatic add_mem(input string name, input load_op_t ld, input store_op_t st,
                           input word_t va, input logic da, input int stall);
        add_test(name, ALU_ADD, va, 32'd0, ld, st, 32'h5a6b_7c8d, 2'b0, da, stall, 1'b0);
    endtask

    task automatic compare_field(input string name, input string field,
                                 input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERROR %s %s: expected %h, actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic run_test(input int n);
        int     lat;
        int     start_acc;
        int     exp_lat;
        es2ms_t held;
        bit     have_held;
        bit     got;
        word_t  exp_res;
        lat = 0;
        have_held = 0;
        got = 0;
        @(negedge clk);
        cur = n;
        start_acc = acc_cnt;
        in_valid = 1'b1;
        in_bus = tbl[n].bus;
        crmd_da = tbl[n].da;
        out_allowin = (tbl[n].stall == 0);
        do @(posedge clk); while (!in_allowin);
        @(negedge clk);
        in_valid = 1'b0;
        if (tbl[n].flush_it) begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            out_allowin = 1'b1;
            repeat (4) begin
                @(posedge clk);
                if (out_valid) begin
                    $display("%s: out_valid seen for a flushed instruction", tbl[n].name);
                    errors++;
                end
            end
            return;
        end
        while (!got) begin
            @(posedge clk);
            lat++;
            if (out_valid && out_allowin) begin
                got = 1;
            end else if (out_valid) begin
                if (have_held && out_bus !== held) begin
                    $display("%s: out_bus changed while stalled", tbl[n].name);
                    errors++;
                end
                held = out_bus;
                have_held = 1;
            end
            if (!got) begin
                @(negedge clk);
                out_allowin = (lat >= tbl[n].stall);
            end
        end
        exp_res = tbl[n].bus.time_op[0] ? ref_cnt[31:0]
                : tbl[n].bus.time_op[1] ? ref_cnt[63:32] : tbl[n].result;
        compare_field(tbl[n].name, "pc", tbl[n].bus.pc, out_bus.pc);
        compare_field(tbl[n].name, "ex", tbl[n].ex, out_bus.ex);
        compare_field(tbl[n].name, "ecode", tbl[n].ecode, out_bus.ecode);
        compare_field(tbl[n].name, "dest", tbl[n].bus.dest, out_bus.dest);
        compare_field(tbl[n].name, "gr_we", tbl[n].bus.gr_we, out_bus.gr_we);
        compare_field(tbl[n].name, "load_op", tbl[n].bus.load_op, out_bus.load_op);
        compare_field(tbl[n].name, "fwd.rf_we", tbl[n].bus.gr_we, fwd.rf_we);
        compare_field(tbl[n].name, "fwd.dest", tbl[n].bus.dest, fwd.dest);
        if (tbl[n].ex) begin
            compare_field(tbl[n].name, "bad_va", tbl[n].bad_va, out_bus.bad_va);
        end else begin
            compare_field(tbl[n].name, "result", exp_res, out_bus.result);
            compare_field(tbl[n].name, "fwd.result", exp_res, fwd.result);
        end
        if (tbl[n].bus.load_op == 0 && tbl[n].bus.store_op == 0 && tbl[n].stall == 0) begin
            exp_lat = (tbl[n].bus.alu_op == ALU_DIV_WU || tbl[n].bus.alu_op == ALU_MOD_WU)
                    ? 34 : 1;
            compare_field(tbl[n].name, "latency", exp_lat, lat);
        end
        @(negedge clk);
        if (acc_cnt - start_acc != (tbl[n].mem ? 1 : 0)) begin
            $display("%s: memory request accepted %0d times", tbl[n].name, acc_cnt - start_acc);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) ref_cnt <= 64'd0;
        else ref_cnt <= ref_cnt + 64'd1;
    end

    always @(posedge clk) begin
        took = mem_en && mem_addr_ok;
        req = mem_en;
        if (took) begin
            acc_cnt++;
            if (!tbl[cur].mem) begin
                $display("%s: memory request where none was expected", tbl[cur].name);
                errors++;
            end
            compare_field(tbl[cur].name, "mem_addr", tbl[cur].result, mem_addr);
            compare_field(tbl[cur].name, "mem_size", tbl[cur].size, mem_size);
            compare_field(tbl[cur].name, "mem_wr", tbl[cur].bus.store_op != 0, mem_wr);
            if (mem_wr) begin
                compare_field(tbl[cur].name, "mem_strb", tbl[cur].strb, mem_strb);
                compare_field(tbl[cur].name, "mem_wdata", tbl[cur].wdata, mem_wdata);
            end
        end
    end

    // memory side answers after 0 to 2 cycles
    initial begin
        mem_addr_ok = 1'b0;
        wait_cnt = 0;
        forever begin
            @(negedge clk);
            if (took) wait_cnt = $urandom_range(0, 2);
            else if (req && wait_cnt != 0) wait_cnt--;
            mem_addr_ok = (wait_cnt == 0);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, DUT stopped responding", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(26));
        reset = 1'b1;
        in_valid = 1'b0;
        in_bus = '0;
        out_allowin = 1'b1;
        flush = 1'b0;
        crmd_da = 1'b1;
        dmw0 = DMW0;
        dmw1 = DMW1;
        tlb_we = 1'b0;
        tlb_windex = '0;
        tlb_wentry = '0;
        tlb_model[0] = '{19'h10000, 1'b0, 20'h12345, 1'b1, 1'b1, 1'b1};
        tlb_model[1] = '{19'h0a000, 1'b1, 20'h55400, 1'b1, 1'b1, 1'b1};  // 4MB page
        tlb_model[2] = '{19'h18000, 1'b0, 20'h00777, 1'b0, 1'b1, 1'b1};
        tlb_model[3] = '{19'h20000, 1'b0, 20'h00888, 1'b1, 1'b0, 1'b1};

        add_alu("add", ALU_ADD, 32'h7fff_ffff, 32'd3, 0);
        add_alu("sub", ALU_SUB, 32'd5, 32'd9, 0);
        add_alu("slt", ALU_SLT, 32'hffff_ffff, 32'd1, 0);
        add_alu("sltu", ALU_SLTU, 32'hffff_ffff, 32'd1, 0);
        add_alu("and", ALU_AND, 32'hf0f0_1234, 32'h0ff0_ffff, 0);
        add_alu("or", ALU_OR, 32'hf000_0001, 32'h0f00_0010, 0);
        add_alu("xor", ALU_XOR, 32'haaaa_5555, 32'hffff_0000, 0);
        add_alu("nor", ALU_NOR, 32'h1234_0000, 32'h0000_5678, 0);
        add_alu("sll", ALU_SLL, 32'h0000_0f0f, 32'd12, 0);
        add_alu("srl", ALU_SRL, 32'h8000_0000, 32'd31, 0);
        add_alu("sra", ALU_SRA, 32'h8000_0000, 32'd4, 2);
        add_alu("lui", ALU_LUI, 32'd0, 32'hbeef_0000, 0);
        add_alu("div_wu", ALU_DIV_WU, 32'd100, 32'd7, 0);
        add_alu("mod_wu", ALU_MOD_WU, 32'hffff_fff0, 32'd9, 0);
        add_alu("div_zero", ALU_DIV_WU, 32'd1234, 32'd0, 0);
        add_alu("mod_zero", ALU_MOD_WU, 32'd1234, 32'd0, 3);
        add_alu("after_div", ALU_ADD, 32'd1, 32'd1, 0);
        add_test("rdcnt_lo", ALU_ADD, 0, 0, 5'b0, 3'b0, 0, 2'b01, 1'b1, 0, 1'b0);
        add_test("rdcnt_hi", ALU_ADD, 0, 0, 5'b0, 3'b0, 0, 2'b10, 1'b1, 0, 1'b0);
        for (int k = 0; k < 4; k++) begin
            add_mem($sformatf("st_b_off%0d", k), 5'b0, ST_B, 32'h1000 + k, 1'b1, 0);
        end
        add_mem("st_h_off0", 5'b0, ST_H, 32'h1000, 1'b1, 0);
        add_mem("st_h_off2", 5'b0, ST_H, 32'h1002, 1'b1, 0);
        add_mem("st_w", 5'b0, ST_W, 32'h1004, 1'b1, 3);
        add_mem("ld_w", LD_W, 3'b0, 32'h2008, 1'b1, 0);
        add_mem("ld_hu", LD_HU, 3'b0, 32'h200a, 1'b1, 2);
        add_mem("ld_h_ale", LD_H, 3'b0, 32'h2001, 1'b1, 0);
        add_mem("st_w_ale", 5'b0, ST_W, 32'h2002, 1'b1, 0);
        add_mem("ld_w_dmw0", LD_W, 3'b0, 32'h8000_1230, 1'b0, 0);
        add_mem("ld_w_dmw1", LD_W, 3'b0, 32'ha000_1234, 1'b0, 0);
        add_mem("ld_w_tlb4k", LD_W, 3'b0, 32'h2000_0abc, 1'b0, 0);
        add_mem("ld_b_tlb4m", LD_B, 3'b0, 32'h1412_3458, 1'b0, 0);
        add_mem("ld_w_tlbr", LD_W, 3'b0, 32'h5000_0000, 1'b0, 0);
        add_mem("ld_w_pil", LD_W, 3'b0, 32'h3000_0010, 1'b0, 0);
        add_mem("st_w_pis", 5'b0, ST_W, 32'h3000_0020, 1'b0, 0);
        add_mem("st_w_pme", 5'b0, ST_W, 32'h4000_0040, 1'b0, 0);
        add_mem("ld_w_clean", LD_W, 3'b0, 32'h4000_0044, 1'b0, 0);
        add_test("flushed", ALU_ADD, 32'd7, 32'd8, 5'b0, 3'b0, 0, 2'b0, 1'b1, 5, 1'b1);
        add_alu("after_flush", ALU_XOR, 32'd3, 32'd5, 0);
        limit = tbl.size() * 40;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < 4; i++) begin
            tlb_we = 1'b1;
            tlb_windex = i[1:0];
            tlb_wentry = tlb_model[i];
            @(negedge clk);
        end
        tlb_we = 1'b0;

        for (int i = 0; i < tbl.size(); i++) begin
            run_test(i);
        end
        repeat (3) @(negedge clk);
        $display("tests run: %0d, errors: %0d", tbl.size(), errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/exe_pkg.sv
hw/alu.sv
hw/tlb_lookup.sv
hw/mmu_translate.sv
hw/exe_stage.sv
hw/exe_top.sv
sim/exe_tb.sv

// File: Bender.yml
package:
  name: exe_stage

sources:
  - hw/exe_pkg.sv
  - hw/alu.sv
  - hw/tlb_lookup.sv
  - hw/mmu_translate.sv
  - hw/exe_stage.sv
  - hw/exe_top.sv
  - target: simulation
    files:
      - sim/exe_tb.sv
